// ==== list.f ====
+incdir+logic
logic/chart_pkg.sv
logic/play_pkg.sv
logic/note_step_if.sv
logic/note_sequencer.sv
logic/score_judge.sv
logic/note_display.sv
logic/record_writer.sv
logic/play_top.sv
sim/tb_play_top.sv

// ==== logic/chart_pkg.sv ====
`include "play_defs.svh"

package chart_pkg;

    // Note word: octave in [8:7], one-hot degree C..B in [6:0]
    typedef logic [8:0] note_t;

    // 00 middle, 01 up, 10 down
    typedef logic [1:0] octave_t;

    // Displayed degree, 1..7 for C..B, 0 blank
    typedef logic [2:0] degree_t;

    // Wide enough to hold CHART_LEN itself as a count
    typedef logic [$clog2(`CHART_LEN + 1)-1:0] note_idx_t;

endpackage

// ==== logic/note_display.sv ====
`timescale 1ns/100ps

module note_display (
    input  logic                prog_clk,
    input  logic                rst,
    note_step_if.sink           steps,
    output logic [7:0]          led,
    output chart_pkg::degree_t  seg_degree,
    output chart_pkg::octave_t  seg_octave
);
    import chart_pkg::*;

    degree_t deg;
    octave_t oct;
    logic    legal;

    assign oct = steps.note[8:7];

    // One-hot degree to its number, anything else blank
    always_comb begin
        case (steps.note[6:0])
            7'b0000001: deg = 3'd1;
            7'b0000010: deg = 3'd2;
            7'b0000100: deg = 3'd3;
            7'b0001000: deg = 3'd4;
            7'b0010000: deg = 3'd5;
            7'b0100000: deg = 3'd6;
            7'b1000000: deg = 3'd7;
            default:    deg = 3'd0;
        endcase
    end

    assign legal = (deg != 3'd0) && (oct != 2'b11);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            led <= '0;
            seg_degree <= '0;
            seg_octave <= '0;
        end
        else if (steps.step) begin
            if (legal) begin
                // C on the leftmost LED, B on bit 1, octave shift on bit 0
                led <= {steps.note[0], steps.note[1], steps.note[2], steps.note[3],
                        steps.note[4], steps.note[5], steps.note[6], oct != 2'b00};
                seg_degree <= deg;
                seg_octave <= oct;
            end
            else begin
                led <= '0;
                seg_degree <= '0;
                seg_octave <= '0;
            end
        end
    end

endmodule

// ==== logic/note_sequencer.sv ====
`timescale 1ns/100ps
`include "play_defs.svh"

module note_sequencer (
    input  logic                 prog_clk,
    input  logic                 rst,
    input  chart_pkg::note_idx_t note_cnt,
    input  chart_pkg::note_t     note_data,
    output chart_pkg::note_idx_t note_addr,
    output logic [1:0]           cnt_dn,
    note_step_if.source          steps
);
    import chart_pkg::*;
    import play_pkg::*;

    // One counter serves both the countdown digits and the step timer
    localparam int CYC_MAX = (`COUNT_CYCLES > `STEP_CYCLES) ? `COUNT_CYCLES : `STEP_CYCLES;
    localparam int CW = $clog2(CYC_MAX);
    localparam logic [CW-1:0] COUNT_LAST = CW'(`COUNT_CYCLES - 1);
    localparam logic [CW-1:0] STEP_LAST = CW'(`STEP_CYCLES - 1);

    seq_state_t    state;
    logic [CW-1:0] cyc_cnt;
    logic          step;
    note_idx_t     next_addr;

    // Step on the first cycle of every step period
    assign step = (state == PLAYING) && (cyc_cnt == '0);
    assign next_addr = note_addr + 1'b1;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state <= COUNTING;
            cyc_cnt <= '0;
            cnt_dn <= 2'd3;
            note_addr <= '0;
        end
        else begin
            case (state)
                COUNTING: begin
                    if (cyc_cnt == COUNT_LAST) begin
                        cyc_cnt <= '0;
                        cnt_dn <= cnt_dn - 2'd1;
                        // Last digit done, an empty chart ends at once
                        if (cnt_dn == 2'd1) begin
                            state <= (note_cnt == '0) ? FINISHED : PLAYING;
                        end
                    end
                    else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                PLAYING: begin
                    cyc_cnt <= (cyc_cnt == STEP_LAST) ? '0 : cyc_cnt + 1'b1;
                    if (step) begin
                        note_addr <= next_addr;
                        if (next_addr >= note_cnt) begin
                            state <= FINISHED;
                        end
                    end
                end
                FINISHED: begin
                    cyc_cnt <= '0;
                end
                default: begin
                    state <= FINISHED;
                end
            endcase
        end
    end

    // Chart data is read straight through during the step
    assign steps.step = step;
    assign steps.note = note_data;
    assign steps.index = note_addr;
    assign steps.playing = (state == PLAYING);
    assign steps.finished = (state == FINISHED);

endmodule

// ==== logic/note_step_if.sv ====
`timescale 1ns/100ps

interface note_step_if;
    import chart_pkg::*;

    // One-cycle pulse per chart step
    logic      step;
    // Valid while step is high
    note_t     note;
    note_idx_t index;
    logic      playing;
    logic      finished;

    modport source (
        output step,
        output note,
        output index,
        output playing,
        output finished
    );

    modport sink (
        input step,
        input note,
        input index,
        input playing,
        input finished
    );

endinterface

// ==== logic/play_defs.svh ====
`ifndef PLAY_DEFS_SVH
`define PLAY_DEFS_SVH

// Chart size in note slots
`define CHART_LEN 64

// Clock cycles per countdown digit, shortened for simulation
`define COUNT_CYCLES 16

// Clock cycles between two note steps
`define STEP_CYCLES 4

// Points by lag between note and key press
`define HIT_FULL 4
`define HIT_LATE 2
`define HIT_LAST 1

`define SCORE_W 14

// Arrow key codes
`define ARROW_LEFT 2'b10
`define ARROW_RIGHT 2'b11

`endif

// ==== logic/play_pkg.sv ====
`include "play_defs.svh"

package play_pkg;

    typedef logic [`SCORE_W-1:0] score_t;

    typedef logic [7:0] user_id_t;
    typedef logic [7:0] chart_id_t;

    // Sequencer phases
    typedef enum logic [1:0] {
        COUNTING,
        PLAYING,
        FINISHED
    } seq_state_t;

    // Exit and save control
    typedef enum logic [2:0] {
        IDLE,
        REQ_WAIT,
        REL_WAIT,
        SAVED,
        MENU
    } writer_state_t;

endpackage

// ==== logic/play_top.sv ====
`timescale 1ns/100ps

module play_top (
    input  logic                 prog_clk,
    input  logic                 rst,
    input  chart_pkg::note_idx_t note_cnt,
    input  chart_pkg::note_t     note_data,
    output chart_pkg::note_idx_t note_addr,
    input  logic                 auto_play,
    input  chart_pkg::note_t     note_keys,
    input  logic [1:0]           arrows,
    input  play_pkg::user_id_t   user_id,
    input  play_pkg::chart_id_t  chart_id,
    output logic [1:0]           cnt_dn,
    output logic                 playing,
    output logic                 finished,
    output play_pkg::score_t     score,
    output logic [7:0]           led,
    output chart_pkg::degree_t   seg_degree,
    output chart_pkg::octave_t   seg_octave,
    output logic                 rec_req,
    output play_pkg::user_id_t   rec_user,
    output play_pkg::chart_id_t  rec_chart,
    output play_pkg::score_t     rec_score,
    input  logic                 rec_ack,
    output logic                 in_menu
);

    // Stepped notes shared by judge, display and writer
    note_step_if steps ();

    note_sequencer u_seq (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .note_cnt  (note_cnt),
        .note_data (note_data),
        .note_addr (note_addr),
        .cnt_dn    (cnt_dn),
        .steps     (steps.source)
    );

    score_judge u_judge (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .auto_play (auto_play),
        .note_keys (note_keys),
        .steps     (steps.sink),
        .score     (score)
    );

    note_display u_disp (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .steps      (steps.sink),
        .led        (led),
        .seg_degree (seg_degree),
        .seg_octave (seg_octave)
    );

    record_writer u_writer (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .arrows    (arrows),
        .user_id   (user_id),
        .chart_id  (chart_id),
        .score     (score),
        .steps     (steps.sink),
        .rec_req   (rec_req),
        .rec_user  (rec_user),
        .rec_chart (rec_chart),
        .rec_score (rec_score),
        .rec_ack   (rec_ack),
        .in_menu   (in_menu)
    );

    assign playing = steps.playing;
    assign finished = steps.finished;

endmodule

// ==== logic/record_writer.sv ====
`timescale 1ns/100ps
`include "play_defs.svh"

module record_writer (
    input  logic                prog_clk,
    input  logic                rst,
    input  logic [1:0]          arrows,
    input  play_pkg::user_id_t  user_id,
    input  play_pkg::chart_id_t chart_id,
    input  play_pkg::score_t    score,
    note_step_if.sink           steps,
    output logic                rec_req,
    output play_pkg::user_id_t  rec_user,
    output play_pkg::chart_id_t rec_chart,
    output play_pkg::score_t    rec_score,
    input  logic                rec_ack,
    output logic                in_menu
);
    import play_pkg::*;

    writer_state_t state;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end
        else begin
            case (state)
                IDLE: begin
                    if (arrows == `ARROW_LEFT) begin
                        state <= MENU;
                    end
                    else if (arrows == `ARROW_RIGHT && steps.finished) begin
                        state <= REQ_WAIT;
                    end
                end
                // Hold the request until the store takes it
                REQ_WAIT: if (rec_ack) state <= REL_WAIT;
                REL_WAIT: if (!rec_ack) state <= SAVED;
                SAVED: if (arrows == `ARROW_LEFT) state <= MENU;
                MENU: state <= MENU;
                default: state <= IDLE;
            endcase
        end
    end

    // Record fields frozen when the save starts
    always_ff @(posedge prog_clk) begin
        if (state == IDLE && arrows == `ARROW_RIGHT && steps.finished) begin
            rec_user <= user_id;
            rec_chart <= chart_id;
            rec_score <= score;
        end
    end

    assign rec_req = (state == REQ_WAIT);
    assign in_menu = (state == MENU);

endmodule

// ==== logic/score_judge.sv ====
`timescale 1ns/100ps
`include "play_defs.svh"

module score_judge (
    input  logic             prog_clk,
    input  logic             rst,
    input  logic             auto_play,
    input  chart_pkg::note_t note_keys,
    note_step_if.sink        steps,
    output play_pkg::score_t score
);
    import chart_pkg::*;
    import play_pkg::*;

    localparam int PW = $clog2(`HIT_FULL + 1);

    // Keys sampled at the last three steps
    note_t         key_lag1;
    note_t         key_lag2;
    note_t         key_lag3;
    logic [PW-1:0] pts;

    // Window of three steps, the earliest lag that matches wins
    always_comb begin
        if (auto_play) begin
            pts = PW'(`HIT_FULL);
        end
        else if (steps.note == note_keys || steps.note == key_lag1) begin
            pts = PW'(`HIT_FULL);
        end
        else if (steps.note == key_lag2) begin
            pts = PW'(`HIT_LATE);
        end
        else if (steps.note == key_lag3) begin
            pts = PW'(`HIT_LAST);
        end
        else begin
            pts = '0;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
            key_lag1 <= '0;
            key_lag2 <= '0;
            key_lag3 <= '0;
        end
        else if (steps.step) begin
            score <= score + score_t'(pts);
            // History shifts in auto play too
            key_lag1 <= note_keys;
            key_lag2 <= key_lag1;
            key_lag3 <= key_lag2;
        end
    end

endmodule

// ==== sim/tb_play_top.sv ====
`timescale 1ns/100ps
`include "play_defs.svh"

module tb_play_top;
    import chart_pkg::*;
    import play_pkg::*;

    localparam int CD_CYCLES = 3 * `COUNT_CYCLES;
    localparam int LEN_SCORED = 48;
    localparam int LEN_AUTO = 24;
    // Three times the countdown, note steps and 50 handshake cycles of each run
    localparam int CYCLE_LIMIT =
        3 * (2 * (CD_CYCLES + 50) + (LEN_SCORED + LEN_AUTO) * `STEP_CYCLES);

    logic       prog_clk;
    logic       rst;
    note_idx_t  note_cnt;
    note_t      note_data;
    note_idx_t  note_addr;
    logic       auto_play;
    note_t      note_keys;
    logic [1:0] arrows;
    user_id_t   user_id;
    chart_id_t  chart_id;
    logic [1:0] cnt_dn;
    logic       playing;
    logic       finished;
    score_t     score;
    logic [7:0] led;
    degree_t    seg_degree;
    octave_t    seg_octave;
    logic       rec_req;
    user_id_t   rec_user;
    chart_id_t  rec_chart;
    score_t     rec_score;
    logic       rec_ack;
    logic       in_menu;

    // Spare slots past the chart end for look-ahead keys
    note_t       chart [0:`CHART_LEN+3];
    logic [31:0] lfsr;
    logic [2:0]  key_sel;
    string       test_name;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    logic        save_pressed;
    logic        left_pressed;
    int          ack_delay;
    logic        ack_armed;

    // Reference model state
    int          clk_n;
    int          req_rises;
    logic        req_prev;
    logic        hs_done;
    int          model_idx;
    logic [12:0] exp_disp;
    score_t      exp_score;
    user_id_t    exp_user;
    chart_id_t   exp_chart;
    note_t       key_lag1;
    note_t       key_lag2;
    note_t       key_lag3;

    play_top dut0 (.*);

    // Chart store with asynchronous read
    assign note_data = chart[note_addr];

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        int i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    // Expected LED, degree and octave of a note as one word
    function automatic logic [12:0] decode_note(note_t n);
        logic [7:0] l;
        degree_t d;
        int ones;
        int k;
        l = '0;
        d = '0;
        ones = 0;
        for (k = 0; k < 7; k++) begin
            if (n[k]) begin
                ones++;
                d = degree_t'(k + 1);
                l[7 - k] = 1'b1;
            end
        end
        // Illegal notes show nothing
        if (ones != 1 || n[8:7] == 2'b11) begin
            return '0;
        end
        l[0] = (n[8:7] != 2'b00);
        return {l, d, n[8:7]};
    endfunction

    function automatic int window_points(note_t n, note_t k0, note_t k1, note_t k2, note_t k3);
        if (n == k0 || n == k1) begin
            return `HIT_FULL;
        end
        if (n == k2) begin
            return `HIT_LATE;
        end
        return (n == k3) ? `HIT_LAST : 0;
    endfunction

    // Chart index taken at cycle c after reset or -1 without a step
    function automatic int step_index(int c);
        if (c < CD_CYCLES || (c - CD_CYCLES) % `STEP_CYCLES != 0) begin
            return -1;
        end
        if ((c - CD_CYCLES) / `STEP_CYCLES >= int'(note_cnt)) begin
            return -1;
        end
        return (c - CD_CYCLES) / `STEP_CYCLES;
    endfunction

    function automatic logic exp_finished(int c);
        return c > CD_CYCLES + (int'(note_cnt) - 1) * `STEP_CYCLES;
    endfunction

    task automatic value_error(string check, logic [31:0] exp, logic [31:0] act);
        errors++;
        $display("ERROR %s %s: expected %0h, actual %0h at %0t",
                 test_name, check, exp, act, $time);
    endtask

    task automatic event_error(string what);
        errors++;
        $display("Failure in %s at %0t: %s", test_name, $time, what);
    endtask

    task automatic fill_chart();
        logic [3:0] kind;
        logic [1:0] oct;
        int deg;
        int i;
        for (i = 0; i <= `CHART_LEN + 3; i++) begin
            kind = 4'(rand_bits(4));
            deg = int'(rand_bits(3)) % 7;
            oct = 2'(int'(rand_bits(2)) % 3);
            chart[i] = {oct, 7'(1 << deg)};
            // A few illegal notes mixed in
            if (kind == 4'd0) begin
                chart[i][(deg + 3) % 7] = 1'b1;
            end
            else if (kind == 4'd1) begin
                chart[i][8:7] = 2'b11;
            end
        end
    endtask

    task automatic start_run(string name, int len, logic autop, user_id_t uid, chart_id_t cid);
        @(negedge prog_clk);
        rst = 1'b1;
        test_name = name;
        note_cnt = note_idx_t'(len);
        auto_play = autop;
        user_id = uid;
        chart_id = cid;
        exp_user = uid;
        exp_chart = cid;
        arrows = '0;
        save_pressed = 1'b0;
        left_pressed = 1'b0;
        errors_at_start = errors;
        repeat (2) @(negedge prog_clk);
        rst = 1'b0;
    endtask

    task automatic finish_test();
        int n;
        n = errors - errors_at_start;
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("Test %s done with %0d errors", test_name, n);
    endtask

    initial begin
        prog_clk = 1'b0;
        forever #5 prog_clk = ~prog_clk;
    end

    always @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            clk_n <= 0;
            req_rises <= 0;
            req_prev <= 1'b0;
            hs_done <= 1'b0;
            exp_disp <= '0;
            exp_score <= '0;
            key_lag1 <= '0;
            key_lag2 <= '0;
            key_lag3 <= '0;
        end
        else begin
            clk_n <= clk_n + 1;
            req_prev <= rec_req;
            if (rec_req && !req_prev) begin
                req_rises <= req_rises + 1;
            end
            hs_done <= hs_done || (req_rises > 0 && !rec_req && !rec_ack);
            model_idx = step_index(clk_n);
            if (model_idx >= 0) begin
                exp_disp <= decode_note(chart[model_idx]);
                exp_score <= exp_score + (auto_play ? score_t'(`HIT_FULL) :
                    score_t'(window_points(chart[model_idx], note_keys,
                                           key_lag1, key_lag2, key_lag3)));
                key_lag1 <= note_keys;
                key_lag2 <= key_lag1;
                key_lag3 <= key_lag2;
            end
        end
    end

    // Keys for the coming step are mostly copies of that note or of one up to three ahead
    always @(negedge prog_clk) begin
        if (step_index(clk_n) >= 0) begin
            key_sel = 3'(rand_bits(3));
            case (key_sel)
                3'd6: note_keys = note_t'(rand_bits(9));
                3'd7: note_keys = '0;
                default: note_keys = chart[step_index(clk_n) + int'(key_sel[1:0])];
            endcase
        end
        // Record store
        if (rec_req && !rec_ack) begin
            if (!ack_armed) begin
                ack_armed = 1'b1;
                ack_delay = int'(rand_bits(3));
            end
            if (ack_delay == 0) begin
                rec_ack = 1'b1;
            end
            else begin
                ack_delay--;
            end
        end
        else if (!rec_req && rec_ack) begin
            rec_ack = 1'b0;
            ack_armed = 1'b0;
        end
    end

    countdown_chk: assert property (@(posedge prog_clk) disable iff (rst)
        clk_n < CD_CYCLES |-> cnt_dn == 2'(3 - clk_n / `COUNT_CYCLES))
        else value_error("cnt_dn", 3 - $sampled(clk_n) / `COUNT_CYCLES, $sampled(cnt_dn));
    playing_chk: assert property (@(posedge prog_clk) disable iff (rst)
        playing == (clk_n >= CD_CYCLES && !exp_finished(clk_n)))
        else value_error("playing", !$sampled(playing), $sampled(playing));
    finished_chk: assert property (@(posedge prog_clk) disable iff (rst)
        finished == exp_finished(clk_n))
        else value_error("finished", !$sampled(finished), $sampled(finished));
    addr_chk: assert property (@(posedge prog_clk) disable iff (rst)
        step_index(clk_n) >= 0 |-> note_addr == step_index(clk_n))
        else value_error("note_addr", step_index($sampled(clk_n)), $sampled(note_addr));
    display_chk: assert property (@(posedge prog_clk) disable iff (rst)
        {led, seg_degree, seg_octave} == exp_disp)
        else value_error("display", $sampled(exp_disp),
                         {$sampled(led), $sampled(seg_degree), $sampled(seg_octave)});
    score_chk: assert property (@(posedge prog_clk) disable iff (rst)
        score == exp_score)
        else value_error("score", $sampled(exp_score), $sampled(score));
    early_save_chk: assert property (@(posedge prog_clk) disable iff (rst)
        !save_pressed |-> !rec_req)
        else event_error("rec_req raised without a right arrow after finished");
    record_chk: assert property (@(posedge prog_clk) disable iff (rst)
        rec_req || rec_ack |->
            {rec_user, rec_chart, rec_score} == {exp_user, exp_chart, exp_score})
        else value_error("record",
                         {$sampled(exp_user), $sampled(exp_chart), $sampled(exp_score)},
                         {$sampled(rec_user), $sampled(rec_chart), $sampled(rec_score)});
    req_hold_chk: assert property (@(posedge prog_clk) disable iff (rst)
        rec_req && !rec_ack |=> rec_req)
        else event_error("rec_req dropped before rec_ack");
    req_release_chk: assert property (@(posedge prog_clk) disable iff (rst)
        rec_ack |=> !rec_req)
        else event_error("rec_req still high after rec_ack");
    single_save_chk: assert property (@(posedge prog_clk) disable iff (rst)
        rec_req && !req_prev |-> req_rises == 0)
        else event_error("second rec_req after a completed save");
    menu_enter_chk: assert property (@(posedge prog_clk) disable iff (rst)
        left_pressed |=> in_menu)
        else event_error("in_menu not high after the left arrow");
    menu_idle_chk: assert property (@(posedge prog_clk) disable iff (rst)
        !left_pressed |-> !in_menu)
        else event_error("in_menu high without a left arrow");

    always @(posedge prog_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles in test %s", cycles, test_name);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        note_cnt = '0;
        auto_play = 1'b0;
        note_keys = '0;
        arrows = '0;
        user_id = '0;
        chart_id = '0;
        rec_ack = 1'b0;
        ack_armed = 1'b0;
        ack_delay = 0;
        save_pressed = 1'b0;
        left_pressed = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        test_name = "reset";
        lfsr = 32'h338;
        fill_chart();

        // Scored play, early right arrow, save, then the menu
        start_run("scored_save", LEN_SCORED, 1'b0, 8'h3c, 8'h91);
        do @(negedge prog_clk); while (!playing);
        repeat (20) @(negedge prog_clk);
        arrows = `ARROW_RIGHT;
        repeat (3) @(negedge prog_clk);
        arrows = '0;
        do @(negedge prog_clk); while (!finished);
        repeat (3) @(negedge prog_clk);
        arrows = `ARROW_RIGHT;
        save_pressed = 1'b1;
        @(negedge prog_clk);
        // Record inputs move on once the save has started
        user_id = ~user_id;
        chart_id = ~chart_id;
        do @(negedge prog_clk); while (!hs_done);
        repeat (4) @(negedge prog_clk);
        arrows = '0;
        save_count_chk: assert (req_rises == 1)
            else event_error("record save did not run exactly once");
        repeat (4) @(negedge prog_clk);
        arrows = `ARROW_LEFT;
        left_pressed = 1'b1;
        @(negedge prog_clk);
        arrows = '0;
        repeat (4) @(negedge prog_clk);
        finish_test();

        // Auto play with a left arrow in the middle of the chart
        start_run("auto_menu", LEN_AUTO, 1'b1, 8'ha5, 8'h0e);
        do @(negedge prog_clk); while (!playing);
        repeat (30) @(negedge prog_clk);
        arrows = `ARROW_LEFT;
        left_pressed = 1'b1;
        @(negedge prog_clk);
        arrows = '0;
        do @(negedge prog_clk); while (!finished);
        repeat (4) @(negedge prog_clk);
        finish_test();

        $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end
        else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
